// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpuTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log
FAILMSG   = TESTS FAILED
PASSMSG   = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG) || { echo "simulation stopped early"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/cpuScoreboard.sv
// compares writebacks and stores with an instruction-level model; programs must end in a jump to itself
`timescale 1ns/100ps
`default_nettype none

module cpuScoreboard #(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         loadEn,
    input  logic [$clog2(imemDepth)-1:0] loadAddr,
    input  cpuPkg::instrT                loadData,
    input  logic                         wbValid,
    input  cpuPkg::regNumT               wbReg,
    input  cpuPkg::wordT                 wbData,
    input  logic                         storeValid,
    input  cpuPkg::wordT                 storeAddr,
    input  cpuPkg::wordT                 storeData,
    output logic                         done,
    output int                           errors
);
    import cpuPkg::*;

    instrT       imemCopy [imemDepth];  // mirror of the instruction memory
    logic [36:0] wbQueue [$];           // {reg, data}
    logic [63:0] storeQueue [$];        // {addr, data}
    logic        modelBuilt;
    logic        runBefore;

    // walks the program at ISA level up to the closing self jump
    task automatic buildExpected();
        wordT   regs [32];
        wordT   dmem [dmemDepth];
        instrT  ins;
        wordT   a;
        wordT   b;
        wordT   simm;
        wordT   addr;
        regNumT dest;
        int     pcIdx;
        int     nextIdx;
        int     memIdx;
        int     steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmemDepth; i++) begin
            dmem[i] = wordT'(i);                    // each word starts as its index
        end
        pcIdx = 0;
        steps = 0;
        while (steps < 4 * imemDepth) begin
            ins     = imemCopy[pcIdx];
            a       = regs[ins[25:21]];
            b       = regs[ins[20:16]];
            simm    = {{16{ins[15]}}, ins[15:0]};
            addr    = a + simm;
            memIdx  = int'((addr >> 2) % dmemDepth);
            dest    = ins[20:16];
            nextIdx = (pcIdx + 1) % imemDepth;
            steps++;
            case (ins[31:26])
                6'h00: begin                        // sub, funct ignored
                    dest = ins[15:11];
                    if (dest != '0) begin
                        regs[dest] = a - b;
                        wbQueue.push_back({dest, a - b});
                    end
                end
                6'h0e: begin
                    if (dest != '0) begin
                        regs[dest] = a ^ simm;
                        wbQueue.push_back({dest, a ^ simm});
                    end
                end
                6'h23: begin
                    if (dest != '0) begin
                        regs[dest] = dmem[memIdx];
                        wbQueue.push_back({dest, dmem[memIdx]});
                    end
                end
                6'h2b: begin
                    storeQueue.push_back({addr, b});
                    dmem[memIdx] = b;
                end
                6'h02: begin
                    nextIdx = int'(ins[25:0]) % imemDepth;
                    if (nextIdx == pcIdx) begin
                        return;                     // end of program
                    end
                end
                default: ;
            endcase
            pcIdx = nextIdx;
        end
        $display("model ran %0d instructions without reaching a jump to itself", steps);
        errors++;
    endtask

    task automatic checkWriteback();
        logic [36:0] exp;
        if (wbQueue.size() == 0) begin
            $display("%0t: writeback to r%0d arrived with none left to expect", $time, wbReg);
            errors++;
        end else begin
            exp = wbQueue.pop_front();
            if (wbReg != exp[36:32]) begin
                $display("Mismatch at %0t: wbReg got %0d, expected %0d", $time, wbReg, exp[36:32]);
                errors++;
            end
            if (wbData != exp[31:0]) begin
                $display("Mismatch at %0t: wbData got %h, expected %h", $time, wbData, exp[31:0]);
                errors++;
            end
        end
    endtask

    task automatic checkStore();
        logic [63:0] exp;
        if (storeQueue.size() == 0) begin
            $display("%0t: store to %h arrived with none left to expect", $time, storeAddr);
            errors++;
        end else begin
            exp = storeQueue.pop_front();
            if (storeAddr != exp[63:32]) begin
                $display("Mismatch at %0t: storeAddr got %h, expected %h",
                         $time, storeAddr, exp[63:32]);
                errors++;
            end
            if (storeData != exp[31:0]) begin
                $display("Mismatch at %0t: storeData got %h, expected %h",
                         $time, storeData, exp[31:0]);
                errors++;
            end
        end
    endtask

    // sampled mid-cycle, away from both edges where things change
    always @(negedge clk) begin
        if (!reset) begin
            wbQueue.delete();
            storeQueue.delete();
            modelBuilt = 1'b0;
            runBefore  = 1'b0;
            errors     = 0;
        end else begin
            if (!run && loadEn) begin
                imemCopy[loadAddr] = loadData;
            end
            if (run && !runBefore) begin
                buildExpected();
                modelBuilt = 1'b1;
            end
            runBefore = run;
            if (wbValid) begin
                checkWriteback();
            end
            if (storeValid) begin
                checkStore();
            end
        end
        done = modelBuilt && wbQueue.size() == 0 && storeQueue.size() == 0;
    end

endmodule

`default_nettype wire

// File: bench/cpuTb.sv
// bench top; generated programs use forward jumps only and never read a load target in the next instruction
`timescale 1ns/100ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int imemDepth   = 64;
    localparam int dmemDepth   = 64;
    localparam int idxW        = $clog2(imemDepth);
    localparam int progLen     = 40;    // fits well inside imemDepth
    localparam int doneTimeout = 500;   // cycles per test

    logic            clk;
    logic            reset;
    logic            run;
    logic            loadEn;
    logic [idxW-1:0] loadAddr;
    instrT           loadData;
    logic            wbValid;
    regNumT          wbReg;
    wordT            wbData;
    logic            storeValid;
    wordT            storeAddr;
    wordT            storeData;
    logic            sbDone;
    int              sbErrors;
    instrT           prog [$];
    int              testsRun;
    int              testsFailed;
    int              seedValue;

    cpuTop #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) u_cpuTop (.*);

    cpuScoreboard #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) scoreboard (
        .*,
        .done   (sbDone),
        .errors (sbErrors)
    );

    always #20 clk = ~clk;

    function automatic instrT iTypeWord(logic [5:0] op, regNumT rs, regNumT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instrT subWord(regNumT rs, regNumT rt, regNumT rd);
        return {6'h00, rs, rt, rd, 5'd0, 6'h22};
    endfunction

    function automatic instrT jumpWord(int idx);
        return {6'h02, 26'(idx)};
    endfunction

    function automatic logic [15:0] alignedOffset();
        return {14'($urandom), 2'b00};      // may be negative, wraps in memory
    endfunction

    // mostly the last two destinations, to exercise both forwarding paths
    function automatic regNumT chooseSource(regNumT first, regNumT second);
        int roll;
        roll = $urandom_range(0, 9);
        if (roll < 4) begin
            return first;
        end else if (roll < 7) begin
            return second;
        end
        return regNumT'($urandom_range(0, 7));
    endfunction

    task automatic referenceProgram();
        prog.delete();
        prog.push_back(iTypeWord(6'h23, 5'd0, 5'd1, 16'd8));      // lw r1, 8(r0)
        prog.push_back(iTypeWord(6'h0e, 5'd0, 5'd2, 16'hfffd));   // xori r2, r0, -3
        prog.push_back(subWord(5'd1, 5'd2, 5'd3));
        prog.push_back(jumpWord(5));
        prog.push_back(subWord(5'd3, 5'd3, 5'd4));                // skipped
        prog.push_back(subWord(5'd3, 5'd1, 5'd5));                // jump target
        prog.push_back(jumpWord(6));
    endtask

    // kind 0 arithmetic only, 1 adds loads and stores, 2 adds forward jumps
    task automatic randomProgram(input int kind);
        regNumT newest;
        regNumT older;
        regNumT lastLoad;
        regNumT rs;
        regNumT rt;
        regNumT rd;
        int     roll;
        int     target;
        prog.delete();
        newest   = 5'd1;
        older    = 5'd2;
        lastLoad = '0;
        while (prog.size() < progLen - 1) begin
            rs   = chooseSource(newest, older);
            rt   = chooseSource(older, newest);
            rd   = regNumT'($urandom_range(1, 7));
            roll = $urandom_range(0, 9);
            if (lastLoad != '0 && rs == lastLoad) begin
                rs = '0;
            end
            if (lastLoad != '0 && rt == lastLoad) begin
                rt = '0;
            end
            lastLoad = '0;
            if (kind == 2 && roll < 2 && prog.size() < progLen - 4) begin
                target = prog.size() + int'($urandom_range(2, 3));
                prog.push_back(jumpWord(target));
                while (prog.size() < target) begin
                    prog.push_back(subWord(rs, rt, rd));    // must never retire
                end
            end else if (kind > 0 && roll < 5) begin
                if (roll < 3) begin
                    prog.push_back(iTypeWord(6'h23, 5'd0, rd, alignedOffset()));
                    lastLoad = rd;
                    older    = newest;
                    newest   = rd;
                end else begin
                    prog.push_back(iTypeWord(6'h2b, 5'd0, rt, alignedOffset()));
                end
            end else begin
                if (roll < 8) begin
                    prog.push_back(subWord(rs, rt, rd));
                end else begin
                    prog.push_back(iTypeWord(6'h0e, rs, rd, 16'($urandom)));
                end
                older  = newest;
                newest = rd;
            end
        end
        prog.push_back(jumpWord(prog.size()));      // park in a jump to itself
    endtask

    task automatic resetCore();
        @(posedge clk);
        #2;
        reset  = 1'b0;
        run    = 1'b0;
        loadEn = 1'b0;
        repeat (5) @(posedge clk);
        #2 reset = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #2;
            loadEn   = 1'b1;
            loadAddr = idxW'(i);
            loadData = prog[i];
        end
        @(posedge clk);
        #2 loadEn = 1'b0;
    endtask

    task automatic runTest(input string name);
        int waited;
        resetCore();
        loadProgram();
        @(posedge clk);
        #2 run = 1'b1;
        waited = 0;
        while (!sbDone && waited < doneTimeout) begin
            @(posedge clk);
            waited++;
        end
        testsRun++;
        if (!sbDone) begin
            $display("test %0d %s: timed out after %0d cycles waiting for events",
                     testsRun, name, waited);
            testsFailed++;
        end else if (sbErrors != 0) begin
            $display("test %0d %s: %0d errors", testsRun, name, sbErrors);
            testsFailed++;
        end else begin
            $display("test %0d %s: ok", testsRun, name);
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;             // first reset gives a real falling edge
        run         = 1'b0;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        testsRun    = 0;
        testsFailed = 0;
        seedValue   = $urandom(32'hc386aabf);
        referenceProgram();
        runTest("reference program");
        for (int t = 0; t < 3; t++) begin
            randomProgram(0);
            runTest("dependent chain");
        end
        for (int t = 0; t < 3; t++) begin
            randomProgram(1);
            runTest("loads and stores");
        end
        for (int t = 0; t < 3; t++) begin
            randomProgram(2);
            runTest("forward jumps");
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/cpuTop_checker.sv
// port assertions bound into every cpuTop; assumes reset is pulsed low before the first program runs
`timescale 1ns/100ps
`default_nettype none

module cpuChecker (
    input logic           clk,
    input logic           reset,
    input logic           run,
    input logic           wbValid,
    input cpuPkg::regNumT wbReg,
    input logic           storeValid,
    input cpuPkg::wordT   storeAddr
);
    // pipeline must be empty while reset is held
    quietInReset: assert property (@(posedge clk) !reset |-> !wbValid && !storeValid)
        else $error("wbValid or storeValid high while reset is low");

    noZeroWrite: assert property (@(posedge clk) disable iff (!reset) wbValid |-> wbReg != '0)
        else $error("writeback reported for register 0");

    alignedStore: assert property (@(posedge clk) disable iff (!reset)
        storeValid |-> storeAddr[1:0] == 2'b00)
        else $error("store address not word-aligned");

    heldQuiet: assert property (@(posedge clk) disable iff (!reset)
        !run |-> !$rose(wbValid) && !$rose(storeValid))
        else $error("event started while run is low");   // loading must stay silent

endmodule

bind cpuTop cpuChecker portChecks (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .storeValid (storeValid),
    .storeAddr  (storeAddr)
);

`default_nettype wire

// File: logic/cpuPkg.sv
// shared types and opcodes for lw, sw, sub, xori and j only; no load-use stall, so a load target must not be read by the next instruction
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;     // data word or byte address
    typedef logic [31:0] instrT;
    typedef logic [4:0]  regNumT;
    typedef logic [5:0]  opcodeT;   // bits 31:26 of the instruction

    localparam opcodeT opcLw   = 6'b100011;
    localparam opcodeT opcSw   = 6'b101011;
    localparam opcodeT opcSub  = 6'b000000;   // R-type, funct not decoded
    localparam opcodeT opcXori = 6'b001110;
    localparam opcodeT opcJ    = 6'b000010;

    // decoded instruction class, carried down the pipe
    typedef enum logic [2:0] {
        opNop,
        opLoad,
        opStore,
        opSub,
        opXori,
        opJump
    } opClassT;

endpackage

`default_nettype wire

// File: logic/cpuTop.sv
// five-stage core top; load the program with run low, and never read a load target in the very next instruction
`timescale 1ns/100ps
`default_nettype none

module cpuTop #(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         loadEn,
    input  logic [$clog2(imemDepth)-1:0] loadAddr,
    input  cpuPkg::instrT                loadData,
    output logic                         wbValid,
    output cpuPkg::regNumT               wbReg,
    output cpuPkg::wordT                 wbData,
    output logic                         storeValid,
    output cpuPkg::wordT                 storeAddr,
    output cpuPkg::wordT                 storeData
);
    import cpuPkg::*;

    logic  fetchValid;
    instrT fetchInstr;

    execBus execLink ();
    memBus  memLink ();
    wbBus   wbLink ();

    fetchUnit #(
        .imemDepth (imemDepth)
    ) fetchStage (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .fetchValid (fetchValid),
        .fetchInstr (fetchInstr)
    );

    decodeUnit decodeStage (
        .clk        (clk),
        .reset      (reset),
        .fetchValid (fetchValid),
        .fetchInstr (fetchInstr),
        .exec       (execLink.producer),
        .wb         (wbLink.consumer)
    );

    executeUnit executeStage (
        .clk    (clk),
        .reset  (reset),
        .exec   (execLink.consumer),
        .mem    (memLink.producer),
        .memTap (memLink.forwardTap),
        .wbTap  (wbLink.forwardTap)
    );

    memoryUnit #(
        .dmemDepth (dmemDepth)
    ) memoryStage (
        .clk        (clk),
        .reset      (reset),
        .mem        (memLink.consumer),
        .wb         (wbLink.producer),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    assign wbValid = wbLink.valid;      // writeback seen as the register write
    assign wbReg   = wbLink.destNum;
    assign wbData  = wbLink.data;

endmodule

`default_nettype wire

// File: logic/decodeUnit.sv
// decode and register read; no load-use interlock, a load target read by the next instruction is stale
`timescale 1ns/100ps
`default_nettype none

module decodeUnit (
    input  logic          clk,
    input  logic          reset,
    input  logic          fetchValid,
    input  cpuPkg::instrT fetchInstr,
    execBus.producer      exec,
    wbBus.consumer        wb
);
    import cpuPkg::*;

    wordT    regs [32];
    opcodeT  opcode;
    opClassT opClass;
    regNumT  rsNum;
    regNumT  rtNum;
    regNumT  rdNum;
    wordT    rsValue;
    wordT    rtValue;

    assign opcode = fetchInstr[31:26];
    assign rsNum  = fetchInstr[25:21];
    assign rtNum  = fetchInstr[20:16];
    assign rdNum  = fetchInstr[15:11];

    always_comb begin
        case (opcode)
            opcLw:   opClass = opLoad;
            opcSw:   opClass = opStore;
            opcSub:  opClass = opSub;
            opcXori: opClass = opXori;
            opcJ:    opClass = opJump;
            default: opClass = opNop;   // unknown opcodes retire silently
        endcase
    end

    // write-through covers the instruction three ahead, now in writeback
    assign rsValue = (wb.valid && wb.destNum == rsNum) ? wb.data : regs[rsNum];
    assign rtValue = (wb.valid && wb.destNum == rtNum) ? wb.data : regs[rtNum];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.destNum] <= wb.data;    // never register 0
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            exec.valid   <= 1'b0;
            exec.opClass <= opNop;
        end else begin
            exec.valid   <= fetchValid && opClass != opNop && opClass != opJump;
            exec.opClass <= opClass;
        end
    end

    always_ff @(posedge clk) begin
        exec.srcA    <= rsValue;
        exec.srcB    <= rtValue;
        exec.imm     <= {{16{fetchInstr[15]}}, fetchInstr[15:0]};
        exec.rsNum   <= rsNum;
        exec.rtNum   <= rtNum;
        exec.destNum <= (opClass == opSub) ? rdNum : rtNum;   // rd only for R-type
    end

endmodule

`default_nettype wire

// File: logic/executeUnit.sv
// execute stage with forwarding from memory and writeback; loads are never forwarded from the memory stage
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
    input logic       clk,
    input logic       reset,
    execBus.consumer  exec,
    memBus.producer   mem,
    memBus.forwardTap memTap,
    wbBus.forwardTap  wbTap
);
    import cpuPkg::*;

    wordT opA;
    wordT opB;
    wordT aluOut;
    logic memHasResult;

    // only sub and xori have their value ready in the memory stage
    assign memHasResult = memTap.valid && (memTap.opClass == opSub || memTap.opClass == opXori);

    function automatic wordT pickSource(regNumT num, wordT decoded);
        if (memHasResult && num != '0 && memTap.destNum == num) begin
            return memTap.aluResult;    // newest producer wins
        end else if (wbTap.valid && num != '0 && wbTap.destNum == num) begin
            return wbTap.data;
        end
        return decoded;
    endfunction

    always_comb begin
        opA = pickSource(exec.rsNum, exec.srcA);
        opB = pickSource(exec.rtNum, exec.srcB);
    end

    always_comb begin
        case (exec.opClass)
            opLoad, opStore: aluOut = opA + exec.imm;   // byte address
            opSub:           aluOut = opA - opB;
            opXori:          aluOut = opA ^ exec.imm;   // immediate stays sign-extended
            default:         aluOut = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mem.valid   <= 1'b0;
            mem.opClass <= opNop;
        end else begin
            mem.valid   <= exec.valid;
            mem.opClass <= exec.opClass;
        end
    end

    always_ff @(posedge clk) begin
        mem.aluResult <= aluOut;
        mem.storeData <= opB;       // forwarded rt for sw
        mem.destNum   <= exec.destNum;
    end

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
// fetch stage; imemDepth must be a power of two, loading works only while run is low
`timescale 1ns/100ps
`default_nettype none

module fetchUnit #(
    parameter int imemDepth = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         loadEn,
    input  logic [$clog2(imemDepth)-1:0] loadAddr,
    input  cpuPkg::instrT                loadData,
    output logic                         fetchValid,
    output cpuPkg::instrT                fetchInstr
);
    import cpuPkg::*;

    localparam int idxW = $clog2(imemDepth);

    instrT imem [imemDepth];    // filled through the load port
    wordT  pc;
    wordT  jumpTarget;
    logic  isJump;

    assign fetchInstr = imem[pc[idxW+1:2]];     // index wraps with the depth
    assign fetchValid = run;
    assign isJump     = fetchInstr[31:26] == opcJ;
    assign jumpTarget = {pc[31:28], fetchInstr[25:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!run && loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;                   // parked at the start while loading
        end else if (isJump) begin
            pc <= jumpTarget;           // slot after the jump never fetched
        end else begin
            pc <= pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: logic/memoryUnit.sv
// memory stage; dmemDepth must be a power of two, word index wraps and low address bits are ignored
`timescale 1ns/100ps
`default_nettype none

module memoryUnit #(
    parameter int dmemDepth = 64
) (
    input  logic         clk,
    input  logic         reset,
    memBus.consumer      mem,
    wbBus.producer       wb,
    output logic         storeValid,
    output cpuPkg::wordT storeAddr,
    output cpuPkg::wordT storeData
);
    import cpuPkg::*;

    localparam int idxW = $clog2(dmemDepth);

    wordT            dmem [dmemDepth];
    logic [idxW-1:0] wordIdx;
    logic            isStore;
    logic            writesReg;

    assign wordIdx   = mem.aluResult[idxW+1:2];     // bits 7:2 at depth 64
    assign isStore   = mem.valid && mem.opClass == opStore;
    assign writesReg = mem.valid && mem.destNum != '0
                       && (mem.opClass == opLoad || mem.opClass == opSub
                           || mem.opClass == opXori);

    assign storeValid = isStore;
    assign storeAddr  = mem.aluResult;
    assign storeData  = mem.storeData;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < dmemDepth; i++) begin
                dmem[i] <= wordT'(i);       // each word starts as its index
            end
        end else if (isStore) begin
            dmem[wordIdx] <= mem.storeData;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= writesReg;
        end
    end

    always_ff @(posedge clk) begin
        wb.destNum <= mem.destNum;
        wb.data    <= (mem.opClass == opLoad) ? dmem[wordIdx] : mem.aluResult;
    end

endmodule

`default_nettype wire

// File: logic/stageBuses.sv
// stage-to-stage links of the core; no handshake, every stage advances each cycle
`timescale 1ns/100ps
`default_nettype none

interface execBus;
    import cpuPkg::*;

    logic    valid;
    opClassT opClass;
    wordT    srcA;      // rs value as read in decode
    wordT    srcB;      // rt value as read in decode
    wordT    imm;       // sign-extended immediate
    regNumT  rsNum;
    regNumT  rtNum;
    regNumT  destNum;

    modport producer (output valid, opClass, srcA, srcB, imm, rsNum, rtNum, destNum);
    modport consumer (input valid, opClass, srcA, srcB, imm, rsNum, rtNum, destNum);
endinterface

interface memBus;
    import cpuPkg::*;

    logic    valid;
    opClassT opClass;
    wordT    aluResult;     // byte address for lw and sw
    wordT    storeData;
    regNumT  destNum;

    modport producer (output valid, opClass, aluResult, storeData, destNum);
    modport consumer (input valid, opClass, aluResult, storeData, destNum);
    modport forwardTap (input valid, opClass, destNum, aluResult);
endinterface

interface wbBus;
    import cpuPkg::*;

    logic   valid;      // only for register writes to a nonzero register
    regNumT destNum;
    wordT   data;

    modport producer (output valid, destNum, data);
    modport consumer (input valid, destNum, data);
    modport forwardTap (input valid, destNum, data);
endinterface

`default_nettype wire

// File: vlog.f
logic/cpuPkg.sv
logic/stageBuses.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/memoryUnit.sv
logic/cpuTop.sv
bench/cpuTop_checker.sv
bench/cpuScoreboard.sv
bench/cpuTb.sv
